//--- rtl/io_config.svh
`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

// Data memory geometry
`define DMEM_WORDS 1024		// Depth in 32-bit words
`define DMEM_AW 10			// Word address width

// UART dump engine
`define DUMP_WORDS 8		// Words per dump, counted from address 0
`define CLKS_PER_BIT 8		// Clock cycles per serial bit

// Push button conditioning
`define DEBOUNCE_CYCLES 16	// Cycles a new level must hold before it is taken

`endif

//--- rtl/io_pkg.sv
`include "io_config.svh"

package io_pkg;

	// Dump controller states
	typedef enum logic [2:0] {
		IDLE,		// Waiting for a button 0 press
		READ,		// Memory read issued
		LOAD,		// Word arrives from memory
		SEND,		// Start strobe towards the UART
		WAIT_TX,	// Frame in flight
		NEXT		// Advance byte or word
	} dump_state_e;

	// Core side write into data memory
	typedef struct packed {
		logic                we;		// Write strobe
		logic [3:0]          be;		// Byte enables, bit 0 is the low byte
		logic [`DMEM_AW-1:0] addr;		// Word address
		logic [31:0]         data;
	} mem_wr_t;

	// Byte request from the dump controller to the transmitter
	typedef struct packed {
		logic       start;		// One cycle strobe
		logic [7:0] data;		// Byte to serialize
	} tx_req_t;

endpackage

//--- rtl/btn_debounce.sv
`include "io_config.svh"

module btn_debounce (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic [3:0] btn,
	output logic [3:0] db_btn
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	logic [3:0]       sync_q1;	// First synchronizer stage, may be metastable
	logic [3:0]       sync_q2;	// Second stage
	logic [CNT_W-1:0] cnt [4];	// Stability counter per channel

	// The stable value only flips after the synchronized input
	// has disagreed with it for the full count
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			db_btn  <= '0;
			for (int i = 0; i < 4; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			sync_q1 <= btn;
			sync_q2 <= sync_q1;
			for (int i = 0; i < 4; i++) begin
				if (sync_q2[i] == db_btn[i]) begin
					cnt[i] <= '0;							// Bounce back, start over
				end else if (cnt[i] == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
					db_btn[i] <= sync_q2[i];				// Held long enough
					cnt[i]    <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

//--- rtl/data_mem.sv
`include "io_config.svh"

module data_mem (
	input  logic                CLK,
	input  io_pkg::mem_wr_t     wr,
	input  logic                rd_en,
	input  logic [`DMEM_AW-1:0] rd_addr,
	output logic [31:0]         rd_data
);

	logic [31:0] mem [`DMEM_WORDS];	// Maps onto block RAM

	// Core port, byte lanes written independently
	always_ff @(posedge CLK) begin
		if (wr.we) begin
			for (int i = 0; i < 4; i++) begin
				if (wr.be[i]) begin
					mem[wr.addr][8*i +: 8] <= wr.data[8*i +: 8];
				end
			end
		end
	end

	// Dump port
	// Same-address collision returns the old word
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];	// Holds between reads
		end
	end

endmodule

//--- rtl/uart_tx.sv
`include "io_config.svh"

module uart_tx (
	input  logic            CLK,
	input  logic            rst_n,
	input  io_pkg::tx_req_t req,
	output logic            tx,
	output logic            busy
);

	localparam int CLK_W = $clog2(`CLKS_PER_BIT);

	logic [9:0]       frame;	// Stop, data LSB first, start in bit 0
	logic [CLK_W-1:0] clk_cnt;	// Position inside the current bit
	logic [3:0]       bit_cnt;	// Bits already sent
	logic             bit_end;	// Last cycle of a bit period

	assign bit_end = (clk_cnt == CLK_W'(`CLKS_PER_BIT - 1));

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (req.start) begin
				busy    <= 1'b1;	// Frame begins next cycle
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;		// Stop bit done
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Frame shifter
	always_ff @(posedge CLK) begin
		if (!busy && req.start) begin
			frame <= {1'b1, req.data, 1'b0};
		end else if (busy && bit_end) begin
			frame <= {1'b1, frame[9:1]};	// Fill with idle level
		end
	end

	assign tx = busy ? frame[0] : 1'b1;	// Line idles high

endmodule

//--- rtl/dump_ctrl.sv
`include "io_config.svh"

module dump_ctrl (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                trig,
	output logic                rd_en,
	output logic [`DMEM_AW-1:0] rd_addr,
	input  logic [31:0]         rd_data,
	output io_pkg::tx_req_t     tx_req,
	input  logic                tx_busy,
	output logic                dump_busy
);

	import io_pkg::*;

	dump_state_e         state;
	logic                trig_q;		// Previous trig for edge detect
	logic                trig_rise;
	logic [`DMEM_AW-1:0] word_addr;		// Word being dumped
	logic [1:0]          byte_cnt;		// Byte within the word
	logic [31:0]         shifter;		// Word split into bytes, low first
	logic                last_word;

	assign trig_rise = trig & ~trig_q;
	assign last_word = (word_addr == `DMEM_AW'(`DUMP_WORDS - 1));

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			trig_q <= 1'b0;
		end else begin
			trig_q <= trig;		// Runs in every state so presses mid dump are lost
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			word_addr <= '0;
			byte_cnt  <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (trig_rise) begin
						state     <= READ;
						word_addr <= '0;	// Dump always starts at address 0
					end
				end
				READ:    state <= LOAD;		// Data valid one cycle later
				LOAD: begin
					state    <= SEND;
					byte_cnt <= '0;
				end
				SEND:    state <= WAIT_TX;
				WAIT_TX: begin
					// Busy is already up on the first cycle here
					if (!tx_busy) begin
						state <= NEXT;
					end
				end
				NEXT: begin
					if (byte_cnt != 2'd3) begin
						byte_cnt <= byte_cnt + 1'b1;
						state    <= SEND;
					end else if (last_word) begin
						state <= IDLE;
					end else begin
						word_addr <= word_addr + 1'b1;
						state     <= READ;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Byte shifter
	always_ff @(posedge CLK) begin
		if (state == LOAD) begin
			shifter <= rd_data;
		end else if (state == NEXT) begin
			shifter <= {8'h00, shifter[31:8]};
		end
	end

	assign rd_en        = (state == READ);
	assign rd_addr      = word_addr;
	assign tx_req.start = (state == SEND);	// Only reached with the UART idle
	assign tx_req.data  = shifter[7:0];
	assign dump_busy    = (state != IDLE);

endmodule

//--- rtl/io_top.sv
`include "io_config.svh"

module io_top (
	input  logic            CLK,
	input  logic            rst_n,
	input  logic [3:0]      btn_in,
	input  logic [2:0]      switch_in,
	input  io_pkg::mem_wr_t core_wr,		// Write port normally owned by the core
	output logic            uart_tx,
	output logic            int_sig,
	output logic [3:0]      db_btn,
	output logic            dump_busy
);

	import io_pkg::*;

	logic                rd_en;		// Dump engine read strobe
	logic [`DMEM_AW-1:0] rd_addr;
	logic [31:0]         rd_data;
	tx_req_t             tx_req;	// Byte towards the serializer
	logic                tx_busy;

	btn_debounce u_debounce (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.btn    (btn_in),
		.db_btn (db_btn)
	);

	data_mem u_dmem (
		.CLK     (CLK),
		.wr      (core_wr),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// Button 0 triggers the dump
	dump_ctrl u_dump (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.trig      (db_btn[0]),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.dump_busy (dump_busy)
	);

	uart_tx u_uart (
		.CLK   (CLK),
		.rst_n (rst_n),
		.req   (tx_req),
		.tx    (uart_tx),
		.busy  (tx_busy)
	);

	// Interrupt level, any debounced button or any switch
	assign int_sig = |db_btn | |switch_in;

endmodule

//--- dv/io_sva.sv
module io_sva (
	input logic            CLK,
	input logic            rst_n,
	input io_pkg::tx_req_t req,
	input logic            busy,
	input logic            tx,
	input logic [3:0]      db_btn,
	input logic [2:0]      switch_in,
	input logic            int_sig
);
	timeunit 1ns;
	timeprecision 100ps;

	int err_cnt = 0;	// Failures seen so far

	// Serial line idles high
	line_idle_high: assert property (@(posedge CLK) disable iff (!rst_n) !busy |-> tx)
		else begin
			err_cnt++;
			$error("UART line low while the transmitter is idle");
		end

	// Controller only strobes an idle transmitter
	no_start_busy: assert property (@(posedge CLK) disable iff (!rst_n) !(req.start && busy))
		else begin
			err_cnt++;
			$error("UART start strobe while the transmitter is busy");
		end

	int_level: assert property (@(posedge CLK) disable iff (!rst_n)
		int_sig == (|db_btn | |switch_in))
		else begin
			err_cnt++;
			$error("Interrupt level differs from buttons OR switches");
		end

endmodule

bind io_top io_sva u_sva (
	.CLK       (CLK),
	.rst_n     (rst_n),
	.req       (tx_req),
	.busy      (tx_busy),
	.tx        (uart_tx),
	.db_btn    (db_btn),
	.switch_in (switch_in),
	.int_sig   (int_sig)
);

//--- dv/io_tb.sv
`include "io_config.svh"

module io_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import io_pkg::*;

	localparam int FRAME_CYCLES = 10 * `CLKS_PER_BIT;
	localparam int BTN_TIMEOUT  = 3 * `DEBOUNCE_CYCLES;	// Sync stages plus full count
	localparam int DUMP_BYTES   = 4 * `DUMP_WORDS;
	localparam int DUMP_TIMEOUT = DUMP_BYTES * (FRAME_CYCLES + 8) + 64;

	logic        CLK = 1'b0;
	logic        rst_n;
	logic [3:0]  btn_in;
	logic [2:0]  switch_in;
	mem_wr_t     core_wr;
	logic        uart_tx;
	logic        int_sig;
	logic [3:0]  db_btn;
	logic        dump_busy;
	logic [31:0] shadow [`DUMP_WORDS];	// Expected contents of the dumped words
	integer      seed = 10;
	int          rx_count = 0;			// Bytes received in the current dump
	int          rx_limit = 0;			// Bytes the current dump may deliver

	io_top dut (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.btn_in    (btn_in),
		.switch_in (switch_in),
		.core_wr   (core_wr),
		.uart_tx   (uart_tx),
		.int_sig   (int_sig),
		.db_btn    (db_btn),
		.dump_busy (dump_busy)
	);

	always #2 CLK = ~CLK;	// 4 ns period

	// Byte n of a dump comes from word n/4 with the low byte first
	function automatic logic [7:0] expected_byte(input logic [31:0] mem [`DUMP_WORDS],
		input int n);
		return mem[n / 4][8 * (n % 4) +: 8];
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) report_failure($sformatf("[FAIL] %s exp 0x%h got 0x%h", name, exp, act));
	endtask

	task automatic check_btn(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) report_failure($sformatf("[FAIL] %s exp 0x%h got 0x%h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) report_failure($sformatf("[FAIL] %s exp 0x%h got 0x%h", name, exp, act));
	endtask

	task automatic wait_btn(input logic [3:0] exp);
		int n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (db_btn !== exp && n < BTN_TIMEOUT);
		if (db_btn !== exp) report_failure("Debounced buttons did not settle in time");
	endtask

	task automatic wait_dump_busy(input logic level, input int limit);
		int n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (dump_busy !== level && n < limit);
		if (dump_busy !== level) report_failure("dump_busy did not change in time");
	endtask

	// Core write with the shadow merging the same byte lanes
	task automatic mem_write(input logic [`DMEM_AW-1:0] addr, input logic [3:0] be,
		input logic [31:0] data);
		@(posedge CLK);
		core_wr <= '{we: 1'b1, be: be, addr: addr, data: data};
		for (int i = 0; i < 4; i++) begin
			if (be[i]) shadow[addr][8*i +: 8] = data[8*i +: 8];
		end
	endtask

	task automatic write_words(input bit full);
		logic [31:0] data;
		for (int a = 0; a < `DUMP_WORDS && full; a++) begin
			data = $random(seed);
			mem_write(`DMEM_AW'(a), 4'hf, data);
		end
		for (int a = 1; a < `DUMP_WORDS; a += 2) begin	// Partial lanes on odd words
			data = $random(seed);
			mem_write(`DMEM_AW'(a), 4'($random(seed)), data);
		end
		@(posedge CLK);
		core_wr <= '0;
	endtask

	task automatic run_dump(input bit extra_press);
		rx_count = 0;
		rx_limit = DUMP_BYTES;
		@(posedge CLK);
		btn_in[0] <= 1'b1;
		wait_dump_busy(1'b1, BTN_TIMEOUT);
		@(posedge CLK);
		btn_in[0] <= 1'b0;
		wait_btn(4'b0000);
		if (extra_press) begin
			@(posedge CLK);
			btn_in[0] <= 1'b1;			// Lands mid dump
			wait_btn(4'b0001);
			check_bit("dump_busy", 1'b1, dump_busy);
			@(posedge CLK);
			btn_in[0] <= 1'b0;
			wait_btn(4'b0000);
		end
		wait_dump_busy(1'b0, DUMP_TIMEOUT);
		if (rx_count != DUMP_BYTES) begin
			report_failure($sformatf("[FAIL] rx_count exp 0x%h got 0x%h", DUMP_BYTES, rx_count));
		end
		repeat (3 * FRAME_CYCLES) begin			// No queued second dump
			@(negedge CLK);
			check_bit("uart_tx", 1'b1, uart_tx);
			check_bit("dump_busy", 1'b0, dump_busy);
		end
		rx_limit = 0;
	endtask

	// Watch the bound checker
	always @(negedge CLK) begin
		if (dut.u_sva.err_cnt != 0) report_failure("A bound assertion failed");
	end

	// UART receiver sampling bit centers on the falling edge
	initial begin : uart_rx
		logic [7:0] rx_byte;
		forever begin
			@(negedge CLK);
			if (uart_tx === 1'b0) begin
				repeat (`CLKS_PER_BIT / 2) @(negedge CLK);
				check_bit("uart_tx start bit", 1'b0, uart_tx);
				for (int i = 0; i < 8; i++) begin
					repeat (`CLKS_PER_BIT) @(negedge CLK);
					rx_byte[i] = uart_tx;		// LSB first
				end
				repeat (`CLKS_PER_BIT) @(negedge CLK);
				check_bit("uart_tx stop bit", 1'b1, uart_tx);
				if (rx_count >= rx_limit) report_failure("UART frame arrived outside a dump");
				check_byte("uart_tx byte", expected_byte(shadow, rx_count), rx_byte);
				rx_count++;
			end
		end
	end

	initial begin : main
		logic [31:0] rand_val;
		logic [3:0]  btn_val;
		logic [2:0]  sw_val;
		rst_n     <= 1'b0;
		btn_in    <= '0;
		switch_in <= 3'b101;
		core_wr   <= '0;
		repeat (3) @(posedge CLK);
		rst_n <= 1'b1;
		@(negedge CLK);
		check_bit("uart_tx", 1'b1, uart_tx);
		check_bit("dump_busy", 1'b0, dump_busy);
		check_btn("db_btn", 4'b0000, db_btn);
		check_bit("int_sig", 1'b1, int_sig);
		// Short glitch must be filtered
		@(posedge CLK);
		btn_in[1] <= 1'b1;
		switch_in <= '0;		// Buttons alone drive int_sig below
		repeat (`DEBOUNCE_CYCLES - 4) @(posedge CLK);
		btn_in[1] <= 1'b0;
		repeat (`DEBOUNCE_CYCLES + 8) begin
			@(negedge CLK);
			check_btn("db_btn", 4'b0000, db_btn);
		end
		for (int b = 1; b < 4; b++) begin
			@(posedge CLK);
			btn_in[b] <= 1'b1;
			wait_btn(4'(1 << b));
			check_bit("int_sig", 1'b1, int_sig);
			@(posedge CLK);
			btn_in[b] <= 1'b0;
			wait_btn(4'b0000);
			check_bit("int_sig", 1'b0, int_sig);
		end
		for (int k = 0; k < 6; k++) begin
			rand_val = $random(seed);
			btn_val  = {rand_val[3:1], 1'b0};	// Button 0 kept free for dumps
			sw_val   = rand_val[6:4];
			@(posedge CLK);
			btn_in    <= btn_val;
			switch_in <= sw_val;
			wait_btn(btn_val);
			check_bit("int_sig", |btn_val | |sw_val, int_sig);
		end
		@(posedge CLK);
		btn_in <= '0;
		wait_btn(4'b0000);
		write_words(1'b1);
		run_dump(1'b0);
		run_dump(1'b1);
		write_words(1'b0);		// New lanes merged onto old words
		run_dump(1'b0);
		if (dut.u_sva.err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "Assertion failures recorded");
		end
	end

endmodule

//--- files.f
+incdir+rtl
rtl/io_pkg.sv
rtl/btn_debounce.sv
rtl/data_mem.sv
rtl/uart_tx.sv
rtl/dump_ctrl.sv
rtl/io_top.sv
dv/io_sva.sv
dv/io_tb.sv
